// ==== field_emitter.sv ====
/*
 * Output register stage. Strobes appear one clock after the emit cycle.
 * tag/value data hold their last loaded text between strobes.
 * checksum_o spans the CheckSum tag strobe up to msg_done_o.
 */
`timescale 1ns/1ps

module field_emitter
	import fix_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       emit_i,
	input  logic       phase_val_i,
	input  field_e     field_i,
	input  logic       msg_end_i,
	input  tag_t       tag_i,
	input  tag_len_t   tag_len_i,
	input  value_t     val_i,
	input  value_len_t val_len_i,
	output tag_t       tag_o,
	output tag_len_t   tag_len_o,
	output logic       tag_valid_o,
	output value_t     val_o,
	output value_len_t val_len_o,
	output logic       val_valid_o,
	output logic       checksum_o,
	output logic       msg_done_o
);

	always_ff @(posedge clk) begin
		if (emit_i) begin
			tag_o <= tag_i;
			tag_len_o <= tag_len_i;
			val_o <= val_i;
			val_len_o <= val_len_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_valid_o <= 1'b0;
			val_valid_o <= 1'b0;
			checksum_o <= 1'b0;
			msg_done_o <= 1'b0;
		end else begin
			tag_valid_o <= emit_i && !phase_val_i;
			val_valid_o <= emit_i && phase_val_i;
			msg_done_o <= msg_end_i;
			if (emit_i && !phase_val_i && field_i == F_CHECKSUM)
				checksum_o <= 1'b1;
			else if (msg_end_i)
				checksum_o <= 1'b0;
		end
	end

	strobe_excl: assert property (@(posedge clk) disable iff (rst)
		!(tag_valid_o && val_valid_o))
		else $error("tag and value strobed together");

endmodule

// ==== field_encoder.sv ====
/*
 * Combinational lookup of tag text and value text for one field.
 * The side not selected by phase_val_i is driven to zero.
 * An unknown message type gives an empty MsgType value.
 * Sending time always has length SENDING_TIME_LEN.
 */
`timescale 1ns/1ps

module field_encoder
	import fix_pkg::*;
(
	input  field_e     field_i,
	input  logic       phase_val_i,
	input  msg_type_t  msg_type_i,
	input  value_t     body_len_i,
	input  value_len_t body_len_len_i,
	input  value_t     seq_num_i,
	input  value_len_t seq_num_len_i,
	input  value_t     sender_comp_id_i,
	input  value_len_t sender_comp_id_len_i,
	input  value_t     target_comp_id_i,
	input  value_len_t target_comp_id_len_i,
	input  value_t     sending_time_i,
	input  value_t     heart_bt_int_i,
	input  value_len_t heart_bt_int_len_i,
	output tag_t       tag_o,
	output tag_len_t   tag_len_o,
	output value_t     val_o,
	output value_len_t val_len_o
);

	tag_t tag;
	tag_len_t tag_len;
	value_t val;
	value_len_t val_len;
	value_t type_val;
	value_len_t type_len;

	always_comb begin
		case (msg_type_i)
		MSG_LOGON:     type_val = VAL_LOGON;
		MSG_HEARTBEAT: type_val = VAL_HEARTBEAT;
		MSG_LOGOUT:    type_val = VAL_LOGOUT;
		default:       type_val = '0;
		endcase
		type_len = msg_type_valid(msg_type_i) ? VAL_MSG_TYPE_LEN : '0;
	end

	always_comb begin
		tag = TAG_CHECKSUM;
		tag_len = TAG_CHECKSUM_LEN;
		val = '0;
		val_len = '0;
		case (field_i)
		F_BEGIN_STRING: begin
			tag = TAG_BEGIN_STRING;
			tag_len = TAG_BEGIN_STRING_LEN;
			val = VAL_BEGIN_STRING;
			val_len = VAL_BEGIN_STRING_LEN;
		end
		F_BODY_LENGTH: begin
			tag = TAG_BODY_LENGTH;
			tag_len = TAG_BODY_LENGTH_LEN;
			val = body_len_i;
			val_len = body_len_len_i;
		end
		F_MSG_SEQ_NUM: begin
			tag = TAG_MSG_SEQ_NUM;
			tag_len = TAG_MSG_SEQ_NUM_LEN;
			val = seq_num_i;
			val_len = seq_num_len_i;
		end
		F_MSG_TYPE: begin
			tag = TAG_MSG_TYPE;
			tag_len = TAG_MSG_TYPE_LEN;
			val = type_val;
			val_len = type_len;
		end
		F_SENDER_COMP_ID: begin
			tag = TAG_SENDER_COMP_ID;
			tag_len = TAG_SENDER_COMP_ID_LEN;
			val = sender_comp_id_i;
			val_len = sender_comp_id_len_i;
		end
		F_SENDING_TIME: begin
			tag = TAG_SENDING_TIME;
			tag_len = TAG_SENDING_TIME_LEN;
			val = sending_time_i;
			val_len = SENDING_TIME_LEN;
		end
		F_TARGET_COMP_ID: begin
			tag = TAG_TARGET_COMP_ID;
			tag_len = TAG_TARGET_COMP_ID_LEN;
			val = target_comp_id_i;
			val_len = target_comp_id_len_i;
		end
		F_ENCRYPT_METHOD: begin
			tag = TAG_ENCRYPT_METHOD;
			tag_len = TAG_ENCRYPT_METHOD_LEN;
			val = VAL_ENCRYPT_NONE;
			val_len = VAL_ENCRYPT_NONE_LEN;
		end
		F_HEART_BT_INT: begin
			tag = TAG_HEART_BT_INT;
			tag_len = TAG_HEART_BT_INT_LEN;
			val = heart_bt_int_i;
			val_len = heart_bt_int_len_i;
		end
		// checksum value is computed downstream
		default: ;
		endcase
	end

	assign tag_o = phase_val_i ? '0 : tag;
	assign tag_len_o = phase_val_i ? '0 : tag_len;
	assign val_o = phase_val_i ? val : '0;
	assign val_len_o = phase_val_i ? val_len : '0;

endmodule

// ==== field_sequencer.sv ====
/*
 * Walks the FIX header/trailer field list, one tag or value at a time.
 * emit_o is combinational from the state and must be registered downstream.
 * Only one item is in flight: the next one waits for done_i.
 * start_i with an unknown type code, or while fifo_full_i is high, is dropped.
 * end_i is taken in WAIT_END regardless of fifo_full_i.
 */
`timescale 1ns/1ps

module field_sequencer
	import fix_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      start_i,
	input  msg_type_t msg_type_i,
	input  logic      done_i,
	input  logic      fifo_full_i,
	input  logic      end_i,
	input  logic      body_len_ready_i,
	input  logic      seq_ready_i,
	output field_e    field_o,
	output logic      phase_val_o,
	output msg_type_t msg_type_o,
	output logic      emit_o,
	output logic      msg_end_o
);

	seq_state_e state_q;
	seq_state_e state_d;
	field_e field_q;
	field_e field_d;
	msg_type_t type_q;
	msg_type_t type_d;
	logic val_ready;

	// field order with logon-only fields dropped for other types
	function automatic field_e next_field(input field_e f, input msg_type_t t);
		field_e n;
		case (f)
		F_BEGIN_STRING:   n = F_BODY_LENGTH;
		F_BODY_LENGTH:    n = F_MSG_SEQ_NUM;
		F_MSG_SEQ_NUM:    n = F_MSG_TYPE;
		F_MSG_TYPE:       n = F_SENDER_COMP_ID;
		F_SENDER_COMP_ID: n = F_SENDING_TIME;
		F_SENDING_TIME:   n = F_TARGET_COMP_ID;
		F_TARGET_COMP_ID: n = (t == MSG_LOGON) ? F_ENCRYPT_METHOD : F_CHECKSUM;
		F_ENCRYPT_METHOD: n = F_HEART_BT_INT;
		default:          n = F_CHECKSUM;
		endcase
		return n;
	endfunction

	// body length and seq num come from outside and may lag
	always_comb begin
		case (field_q)
		F_BODY_LENGTH: val_ready = body_len_ready_i;
		F_MSG_SEQ_NUM: val_ready = seq_ready_i;
		default:       val_ready = 1'b1;
		endcase
	end

	always_comb begin
		state_d = state_q;
		field_d = field_q;
		type_d = type_q;
		emit_o = 1'b0;
		msg_end_o = 1'b0;
		case (state_q)
		IDLE: begin
			if (start_i && !fifo_full_i && msg_type_valid(msg_type_i)) begin
				type_d = msg_type_i;
				field_d = F_BEGIN_STRING;
				state_d = SEND_TAG;
			end
		end
		SEND_TAG: begin
			if (!fifo_full_i) begin
				emit_o = 1'b1;
				state_d = WAIT_TAG;
			end
		end
		WAIT_TAG: begin
			// checksum has no value of its own here
			if (done_i) begin
				state_d = (field_q == F_CHECKSUM) ? WAIT_END : SEND_VAL;
			end
		end
		SEND_VAL: begin
			if (!fifo_full_i && val_ready) begin
				emit_o = 1'b1;
				state_d = WAIT_VAL;
			end
		end
		WAIT_VAL: begin
			if (done_i) begin
				field_d = next_field(field_q, type_q);
				state_d = SEND_TAG;
			end
		end
		WAIT_END: begin
			if (end_i) begin
				msg_end_o = 1'b1;
				state_d = IDLE;
			end
		end
		default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
			field_q <= F_BEGIN_STRING;
			type_q <= '0;
		end else begin
			state_q <= state_d;
			field_q <= field_d;
			type_q <= type_d;
		end
	end

	assign field_o = field_q;
	assign msg_type_o = type_q;
	assign phase_val_o = (state_q == SEND_VAL) || (state_q == WAIT_VAL);

	emit_no_stall: assert property (@(posedge clk) disable iff (rst)
		emit_o |-> !fifo_full_i)
		else $error("emit while fifo full");

	// at most one item outstanding
	emit_single: assert property (@(posedge clk) disable iff (rst)
		emit_o |=> !emit_o)
		else $error("emit held for more than one cycle");

endmodule

// ==== fix_msg_builder.f ====
fix_pkg.sv
field_sequencer.sv
field_encoder.sv
field_emitter.sv
fix_msg_builder.sv
tb_fix_msg_builder.sv

// ==== fix_msg_builder.sv ====
/*
 * FIX session header/trailer builder for Logon, Heartbeat and Logout.
 * Emits tag and value strobes to a serializer that answers each with done_i.
 * Body length, sequence number and checksum arithmetic live outside.
 * First tag strobe comes 2 cycles after start_i when not stalled.
 */
`timescale 1ns/1ps

module fix_msg_builder
	import fix_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start_i,
	input  msg_type_t  msg_type_i,
	input  logic       done_i,
	input  logic       fifo_full_i,
	input  logic       end_i,
	input  logic       body_len_ready_i,
	input  logic       seq_ready_i,
	input  value_t     body_len_i,
	input  value_len_t body_len_len_i,
	input  value_t     seq_num_i,
	input  value_len_t seq_num_len_i,
	input  value_t     sender_comp_id_i,
	input  value_len_t sender_comp_id_len_i,
	input  value_t     target_comp_id_i,
	input  value_len_t target_comp_id_len_i,
	input  value_t     sending_time_i,
	input  value_t     heart_bt_int_i,
	input  value_len_t heart_bt_int_len_i,
	output tag_t       tag_o,
	output tag_len_t   tag_len_o,
	output logic       tag_valid_o,
	output value_t     val_o,
	output value_len_t val_len_o,
	output logic       val_valid_o,
	output logic       checksum_o,
	output logic       msg_done_o
);

	field_e field;
	logic phase_val;
	msg_type_t msg_type;
	logic emit;
	logic msg_end;
	tag_t enc_tag;
	tag_len_t enc_tag_len;
	value_t enc_val;
	value_len_t enc_val_len;

	field_sequencer u_seq (
		.clk              (clk),
		.rst              (rst),
		.start_i          (start_i),
		.msg_type_i       (msg_type_i),
		.done_i           (done_i),
		.fifo_full_i      (fifo_full_i),
		.end_i            (end_i),
		.body_len_ready_i (body_len_ready_i),
		.seq_ready_i      (seq_ready_i),
		.field_o          (field),
		.phase_val_o      (phase_val),
		.msg_type_o       (msg_type),
		.emit_o           (emit),
		.msg_end_o        (msg_end)
	);

	field_encoder u_enc (
		.field_i              (field),
		.phase_val_i          (phase_val),
		.msg_type_i           (msg_type),
		.body_len_i           (body_len_i),
		.body_len_len_i       (body_len_len_i),
		.seq_num_i            (seq_num_i),
		.seq_num_len_i        (seq_num_len_i),
		.sender_comp_id_i     (sender_comp_id_i),
		.sender_comp_id_len_i (sender_comp_id_len_i),
		.target_comp_id_i     (target_comp_id_i),
		.target_comp_id_len_i (target_comp_id_len_i),
		.sending_time_i       (sending_time_i),
		.heart_bt_int_i       (heart_bt_int_i),
		.heart_bt_int_len_i   (heart_bt_int_len_i),
		.tag_o                (enc_tag),
		.tag_len_o            (enc_tag_len),
		.val_o                (enc_val),
		.val_len_o            (enc_val_len)
	);

	field_emitter u_emit (
		.clk         (clk),
		.rst         (rst),
		.emit_i      (emit),
		.phase_val_i (phase_val),
		.field_i     (field),
		.msg_end_i   (msg_end),
		.tag_i       (enc_tag),
		.tag_len_i   (enc_tag_len),
		.val_i       (enc_val),
		.val_len_i   (enc_val_len),
		.tag_o       (tag_o),
		.tag_len_o   (tag_len_o),
		.tag_valid_o (tag_valid_o),
		.val_o       (val_o),
		.val_len_o   (val_len_o),
		.val_valid_o (val_valid_o),
		.checksum_o  (checksum_o),
		.msg_done_o  (msg_done_o)
	);

endmodule

// ==== fix_pkg.sv ====
/*
 * Shared widths and constants for the FIX session header/trailer builder.
 * Text fields are ASCII, right-aligned, zero-padded on the left.
 * Values longer than VALUE_CHARS characters cannot be carried.
 * Only FIX.4.2 Logon, Heartbeat and Logout are covered.
 */
package fix_pkg;

	localparam int VALUE_CHARS = 8;

	typedef logic [31:0] tag_t;
	typedef logic [2:0] tag_len_t;
	typedef logic [VALUE_CHARS*8-1:0] value_t;
	typedef logic [$clog2(VALUE_CHARS+1)-1:0] value_len_t;
	typedef logic [3:0] msg_type_t;

	// one-hot message type codes
	localparam msg_type_t MSG_LOGON = 4'b0001;
	localparam msg_type_t MSG_HEARTBEAT = 4'b0010;
	localparam msg_type_t MSG_LOGOUT = 4'b0100;

	// fields in send order
	typedef enum logic [3:0] {
		F_BEGIN_STRING,
		F_BODY_LENGTH,
		F_MSG_SEQ_NUM,
		F_MSG_TYPE,
		F_SENDER_COMP_ID,
		F_SENDING_TIME,
		F_TARGET_COMP_ID,
		F_ENCRYPT_METHOD,
		F_HEART_BT_INT,
		F_CHECKSUM
	} field_e;

	typedef enum logic [2:0] {
		IDLE,
		SEND_TAG,
		WAIT_TAG,
		SEND_VAL,
		WAIT_VAL,
		WAIT_END
	} seq_state_e;

	// tag numbers as text
	localparam tag_t TAG_BEGIN_STRING = "8";
	localparam tag_t TAG_BODY_LENGTH = "9";
	localparam tag_t TAG_MSG_SEQ_NUM = "34";
	localparam tag_t TAG_MSG_TYPE = "35";
	localparam tag_t TAG_SENDER_COMP_ID = "49";
	localparam tag_t TAG_SENDING_TIME = "52";
	localparam tag_t TAG_TARGET_COMP_ID = "56";
	localparam tag_t TAG_ENCRYPT_METHOD = "98";
	localparam tag_t TAG_HEART_BT_INT = "108";
	localparam tag_t TAG_CHECKSUM = "10";

	localparam tag_len_t TAG_BEGIN_STRING_LEN = 3'd1;
	localparam tag_len_t TAG_BODY_LENGTH_LEN = 3'd1;
	localparam tag_len_t TAG_MSG_SEQ_NUM_LEN = 3'd2;
	localparam tag_len_t TAG_MSG_TYPE_LEN = 3'd2;
	localparam tag_len_t TAG_SENDER_COMP_ID_LEN = 3'd2;
	localparam tag_len_t TAG_SENDING_TIME_LEN = 3'd2;
	localparam tag_len_t TAG_TARGET_COMP_ID_LEN = 3'd2;
	localparam tag_len_t TAG_ENCRYPT_METHOD_LEN = 3'd2;
	localparam tag_len_t TAG_HEART_BT_INT_LEN = 3'd3;
	localparam tag_len_t TAG_CHECKSUM_LEN = 3'd2;

	// fixed values
	localparam value_t VAL_BEGIN_STRING = "FIX.4.2";
	localparam value_len_t VAL_BEGIN_STRING_LEN = 4'd7;
	localparam value_t VAL_ENCRYPT_NONE = "0";
	localparam value_len_t VAL_ENCRYPT_NONE_LEN = 4'd1;
	localparam value_t VAL_LOGON = "A";
	localparam value_t VAL_HEARTBEAT = "0";
	localparam value_t VAL_LOGOUT = "5";
	localparam value_len_t VAL_MSG_TYPE_LEN = 4'd1;

	// sending time is carried as HH:MM:SS
	localparam value_len_t SENDING_TIME_LEN = 4'd8;

	function automatic logic msg_type_valid(input msg_type_t t);
		return (t == MSG_LOGON) || (t == MSG_HEARTBEAT) || (t == MSG_LOGOUT);
	endfunction

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build the FIX message builder testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fix_msg_builder \
	--Mdir obj_dir -o sim_fix_msg_builder \
	-f fix_msg_builder.f; then
	echo "verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/sim_fix_msg_builder); then
	echo "$output"
	echo "simulation exited with an error"
	exit 1
fi

echo "$output"
if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

// ==== tb_fix_msg_builder.sv ====
/*
 * Testbench for fix_msg_builder. A serializer model answers each strobe
 * with done_i after 1 to 4 cycles and raises end_i after the CheckSum tag.
 * Concurrent assertions compare every strobe with an expected field list.
 * All DUT inputs change on the falling clock edge only.
 */
`timescale 1ns/1ps

module tb_fix_msg_builder
	import fix_pkg::*;
();

	localparam int MSG_CYCLES = 500;
	// upper bound on messages per run with margin
	localparam int MSG_BUDGET = 40;
	localparam int WATCHDOG_CYCLES = MSG_CYCLES * MSG_BUDGET;

	logic clk;
	logic rst;
	logic start_i;
	msg_type_t msg_type_i;
	logic done_i;
	logic fifo_full_i;
	logic end_i;
	logic body_len_ready_i;
	logic seq_ready_i;
	value_t body_len_i;
	value_len_t body_len_len_i;
	value_t seq_num_i;
	value_len_t seq_num_len_i;
	value_t sender_comp_id_i;
	value_len_t sender_comp_id_len_i;
	value_t target_comp_id_i;
	value_len_t target_comp_id_len_i;
	value_t sending_time_i;
	value_t heart_bt_int_i;
	value_len_t heart_bt_int_len_i;
	tag_t tag_o;
	tag_len_t tag_len_o;
	logic tag_valid_o;
	value_t val_o;
	value_len_t val_len_o;
	logic val_valid_o;
	logic checksum_o;
	logic msg_done_o;

	// expected field list of the current message
	tag_t exp_tag [10];
	tag_len_t exp_tag_len [10];
	value_t exp_val [10];
	value_len_t exp_val_len [10];
	int exp_tags;
	int exp_vals;
	int tag_count;
	int val_count;

	value_t body_val;
	value_t seq_val;
	logic [31:0] rng_stim;
	logic [31:0] rng_bus;
	int done_cnt;
	int end_cnt;
	int body_cnt;
	int seq_cnt;
	int burst_cnt;
	int ready_max;
	logic start_req;
	logic stall_en;
	logic quiet_expect;
	logic latency_check;
	string test_name;
	int err_count;
	int test_errs;
	int tests_run;
	int tests_failed;

	fix_msg_builder dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic int stim_rand(input int n);
		rng_stim = xorshift32(rng_stim);
		return int'(rng_stim % n);
	endfunction

	function automatic int bus_rand(input int n);
		rng_bus = xorshift32(rng_bus);
		return int'(rng_bus % n);
	endfunction

	// right-aligned text of len characters from base .. base+span-1
	function automatic value_t rand_text(input int len, input byte base, input int span);
		value_t t;
		t = '0;
		for (int i = 0; i < len; i++) begin
			t = {t[55:0], 8'(base + stim_rand(span))};
		end
		return t;
	endfunction

	function automatic msg_type_t pick_type();
		case (stim_rand(3))
		0:       return MSG_LOGON;
		1:       return MSG_HEARTBEAT;
		default: return MSG_LOGOUT;
		endcase
	endfunction

	task automatic add_field(input tag_t t, input tag_len_t tl, input value_t v,
		input value_len_t vl, input logic has_val);
		exp_tag[exp_tags] = t;
		exp_tag_len[exp_tags] = tl;
		exp_tags++;
		if (has_val) begin
			exp_val[exp_vals] = v;
			exp_val_len[exp_vals] = vl;
			exp_vals++;
		end
	endtask

	// FIX header and trailer order with two extra logon fields
	task automatic build_expected(input msg_type_t t);
		value_t type_text;
		type_text = (t == MSG_LOGON) ? "A" : (t == MSG_HEARTBEAT) ? "0" : "5";
		exp_tags = 0;
		exp_vals = 0;
		add_field("8", 3'd1, "FIX.4.2", 4'd7, 1'b1);
		add_field("9", 3'd1, body_val, body_len_len_i, 1'b1);
		add_field("34", 3'd2, seq_val, seq_num_len_i, 1'b1);
		add_field("35", 3'd2, type_text, 4'd1, 1'b1);
		add_field("49", 3'd2, sender_comp_id_i, sender_comp_id_len_i, 1'b1);
		add_field("52", 3'd2, sending_time_i, 4'd8, 1'b1);
		add_field("56", 3'd2, target_comp_id_i, target_comp_id_len_i, 1'b1);
		if (t == MSG_LOGON) begin
			add_field("98", 3'd2, "0", 4'd1, 1'b1);
			add_field("108", 3'd3, heart_bt_int_i, heart_bt_int_len_i, 1'b1);
		end
		add_field("10", 3'd2, '0, 4'd0, 1'b0);
	endtask

	// stalls, start, ready levels, serializer done and end_i on the bus side
	always @(negedge clk) begin
		if (!rst) begin
			if (burst_cnt > 0)
				burst_cnt--;
			else if (stall_en && bus_rand(8) == 0)
				burst_cnt = 1 + bus_rand(4);
			fifo_full_i <= (burst_cnt > 0);
			start_i <= 1'b0;
			if (start_req && burst_cnt == 0) begin
				start_i <= 1'b1;
				start_req = 1'b0;
				tag_count = 0;
				val_count = 0;
				body_cnt = (ready_max > 0) ? bus_rand(ready_max) : 0;
				seq_cnt = (ready_max > 0) ? bus_rand(ready_max) : 0;
			end
			if (body_cnt > 0)
				body_cnt--;
			if (seq_cnt > 0)
				seq_cnt--;
			body_len_ready_i <= (body_cnt == 0);
			seq_ready_i <= (seq_cnt == 0);
			// stale text while not ready
			body_len_i <= (body_cnt == 0) ? body_val : "????????";
			seq_num_i <= (seq_cnt == 0) ? seq_val : "????????";
			end_i <= 1'b0;
			if (end_cnt > 0) begin
				end_cnt--;
				if (end_cnt == 0)
					end_i <= 1'b1;
			end
			done_i <= 1'b0;
			if (done_cnt > 0) begin
				done_cnt--;
				if (done_cnt == 0) begin
					done_i <= 1'b1;
					if (checksum_o)
						end_cnt = 1 + bus_rand(4);
				end
			end
			if (tag_valid_o)
				tag_count++;
			if (val_valid_o)
				val_count++;
			if (tag_valid_o || val_valid_o)
				done_cnt = 1 + bus_rand(4);
		end
	end

	task automatic value_error(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		err_count++;
		$display("error %s: %s expected %h actual %h", test_name, what, exp, act);
	endtask

	task automatic plain_error(input string msg);
		err_count++;
		$display("%s: %s", test_name, msg);
	endtask

	tag_text: assert property (@(posedge clk) disable iff (rst)
		tag_valid_o |-> (tag_count >= 1 && tag_count <= exp_tags
			&& tag_o == exp_tag[tag_count-1]))
		else value_error("tag text", exp_tag[tag_count-1], tag_o);

	tag_length: assert property (@(posedge clk) disable iff (rst)
		tag_valid_o |-> tag_len_o == exp_tag_len[tag_count-1])
		else value_error("tag length", exp_tag_len[tag_count-1], tag_len_o);

	val_text: assert property (@(posedge clk) disable iff (rst)
		val_valid_o |-> (val_count >= 1 && val_count <= exp_vals
			&& val_o == exp_val[val_count-1]))
		else value_error("value text", exp_val[val_count-1], val_o);

	val_length: assert property (@(posedge clk) disable iff (rst)
		val_valid_o |-> val_len_o == exp_val_len[val_count-1])
		else value_error("value length", exp_val_len[val_count-1], val_len_o);

	strobe_total: assert property (@(posedge clk) disable iff (rst)
		msg_done_o |-> (tag_count == exp_tags && val_count == exp_vals))
		else plain_error("message ended with a wrong number of tag or value strobes");

	no_strobe_after_full: assert property (@(posedge clk) disable iff (rst)
		fifo_full_i |=> !(tag_valid_o || val_valid_o))
		else plain_error("strobe in the cycle after fifo_full_i was high");

	body_len_waits: assert property (@(posedge clk) disable iff (rst)
		(val_valid_o && val_count == 2) |-> $past(body_len_ready_i))
		else plain_error("BodyLength value sent while its ready was low");

	seq_num_waits: assert property (@(posedge clk) disable iff (rst)
		(val_valid_o && val_count == 3) |-> $past(seq_ready_i))
		else plain_error("MsgSeqNum value sent while its ready was low");

	checksum_rise: assert property (@(posedge clk) disable iff (rst)
		(tag_valid_o && tag_o == "10") |-> checksum_o)
		else plain_error("checksum flag low on the CheckSum tag strobe");

	checksum_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(checksum_o) |-> msg_done_o)
		else plain_error("checksum flag dropped before msg_done_o");

	done_after_end: assert property (@(posedge clk) disable iff (rst)
		(end_i && checksum_o) |=> msg_done_o)
		else plain_error("msg_done_o missing one cycle after end_i");

	done_needs_end: assert property (@(posedge clk) disable iff (rst)
		msg_done_o |-> $past(end_i))
		else plain_error("msg_done_o without a preceding end_i");

	quiet_on_invalid: assert property (@(posedge clk) disable iff (rst)
		quiet_expect |-> !(tag_valid_o || val_valid_o))
		else plain_error("strobe after start_i with an invalid type code");

	first_tag_latency: assert property (@(posedge clk) disable iff (rst)
		(latency_check && tag_valid_o && tag_count == 1) |-> $past(start_i, 2))
		else plain_error("first tag strobe not 2 cycles after start_i");

	task automatic run_message(input msg_type_t t);
		int n;
		@(negedge clk);
		msg_type_i = t;
		n = 1 + stim_rand(3);
		body_val = rand_text(n, "0", 10);
		body_len_len_i = value_len_t'(n);
		n = 1 + stim_rand(4);
		seq_val = rand_text(n, "0", 10);
		seq_num_len_i = value_len_t'(n);
		n = 1 + stim_rand(8);
		sender_comp_id_i = rand_text(n, "A", 26);
		sender_comp_id_len_i = value_len_t'(n);
		n = 1 + stim_rand(8);
		target_comp_id_i = rand_text(n, "A", 26);
		target_comp_id_len_i = value_len_t'(n);
		sending_time_i = rand_text(8, "0", 10);
		n = 1 + stim_rand(3);
		heart_bt_int_i = rand_text(n, "0", 10);
		heart_bt_int_len_i = value_len_t'(n);
		build_expected(t);
		@(posedge clk);
		start_req = 1'b1;
		wait (!start_req);
		do @(negedge clk); while (!msg_done_o);
	endtask

	task automatic start_invalid(input msg_type_t t);
		@(negedge clk);
		msg_type_i = t;
		@(posedge clk);
		start_req = 1'b1;
		wait (!start_req);
		repeat (20) @(negedge clk);
	endtask

	task automatic begin_test(input string name, input logic stall, input int ready);
		@(posedge clk);
		test_name = name;
		stall_en = stall;
		ready_max = ready;
		test_errs = err_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_count == test_errs) begin
			$display("%s: pass", test_name);
		end else begin
			tests_failed++;
			$display("%s: fail with %0d errors", test_name, err_count - test_errs);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	initial begin
		rng_stim = 32'h1d35_72b9;
		rng_bus = xorshift32(32'h1d35_72b9);
		rst = 1'b1;
		start_i = 1'b0;
		msg_type_i = '0;
		done_i = 1'b0;
		fifo_full_i = 1'b0;
		end_i = 1'b0;
		body_len_ready_i = 1'b1;
		seq_ready_i = 1'b1;
		body_len_i = '0;
		body_len_len_i = '0;
		seq_num_i = '0;
		seq_num_len_i = '0;
		sender_comp_id_i = '0;
		sender_comp_id_len_i = '0;
		target_comp_id_i = '0;
		target_comp_id_len_i = '0;
		sending_time_i = '0;
		heart_bt_int_i = '0;
		heart_bt_int_len_i = '0;
		body_val = '0;
		seq_val = '0;
		exp_tags = 0;
		exp_vals = 0;
		tag_count = 0;
		val_count = 0;
		done_cnt = 0;
		end_cnt = 0;
		body_cnt = 0;
		seq_cnt = 0;
		burst_cnt = 0;
		ready_max = 0;
		start_req = 1'b0;
		stall_en = 1'b0;
		quiet_expect = 1'b0;
		latency_check = 1'b0;
		test_name = "reset";
		err_count = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		begin_test("logon", 1'b0, 0);
		run_message(MSG_LOGON);
		run_message(MSG_LOGON);
		end_test();

		begin_test("heartbeat_logout", 1'b0, 0);
		run_message(MSG_HEARTBEAT);
		run_message(MSG_LOGOUT);
		end_test();

		begin_test("random_stalls", 1'b1, 0);
		repeat (6) run_message(pick_type());
		end_test();

		begin_test("ready_wait", 1'b1, 16);
		repeat (4) run_message(pick_type());
		end_test();

		begin_test("checksum_restart", 1'b0, 0);
		run_message(MSG_LOGOUT);
		run_message(MSG_LOGON);
		end_test();

		begin_test("invalid_type_latency", 1'b0, 0);
		quiet_expect = 1'b1;
		start_invalid(4'b0000);
		start_invalid(4'b0011);
		start_invalid(4'b1000);
		quiet_expect = 1'b0;
		latency_check = 1'b1;
		run_message(MSG_HEARTBEAT);
		latency_check = 1'b0;
		end_test();

		$display("%0d tests run, %0d failing, %0d errors",
			tests_run, tests_failed, err_count);
		if (err_count == 0 && tests_failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
